//--- hw/canBridgePkg.sv
`default_nettype none

package canBridgePkg;

   // receive register map of the CAN controller
   localparam logic [4:0] RegId  = 5'd5;         // identifier register
   localparam logic [4:0] RegB12 = 5'd3;         // data bytes 1 and 2
   localparam logic [4:0] RegB34 = 5'd2;         // data bytes 3 and 4
   localparam logic [4:0] RegB56 = 5'd1;         // data bytes 5 and 6
   localparam logic [4:0] RegB78 = 5'd0;         // data bytes 7 and 8

   // SDO request (client to server) COB-ID base
   localparam logic [10:0] SdoRxBase = 11'h600;  // plus node id

   // configuration register map
   localparam logic [1:0] CfgCtrl  = 2'd0;       // bit 0 enable
   localparam logic [1:0] CfgNode  = 2'd1;       // node id, 7 bits
   localparam logic [1:0] CfgCount = 2'd2;       // accepted requests

   // 12-bit id field plus eight data bytes
   localparam int MsgWidth = 76;

   // read sequencer states, one per register read
   typedef enum logic [2:0] {
      SeqIdle = 3'd0,                            // waiting for a frame
      SeqId   = 3'd1,                            // reading identifier
      SeqB12  = 3'd2,
      SeqB34  = 3'd3,
      SeqB56  = 3'd4,
      SeqB78  = 3'd5,                            // last data read
      SeqDone = 3'd6                             // message complete
   } SeqState;

   // decoded SDO request kind
   typedef enum logic [1:0] {
      SdoNone     = 2'd0,                        // not for this node
      SdoDownload = 2'd1,                        // ccs 1, expedited write
      SdoUpload   = 2'd2,                        // ccs 2, read request
      SdoOther    = 2'd3                         // any other ccs
   } SdoOp;

endpackage

`default_nettype wire

//--- hw/recMesBuf.sv
`timescale 1ns/1ps
`default_nettype none

module recMesBuf
   import canBridgePkg::*;
(
   input  wire logic                clk,
   input  wire logic                rst,      // async, active low
   input  wire logic [15:0]         data,     // one receive register
   input  wire logic                en,       // capture strobe
   input  wire logic [4:0]          addr,     // controller register address
   output logic      [MsgWidth-1:0] msgWord,  // id and all data bytes
   output logic      [7:0]          sdoCmd,   // SDO command byte
   output logic      [10:0]         curId     // id of the frame in work
);

   logic [11:0] id;                           // bit 11 stays zero
   logic [7:0]  b1;                           // data bytes in frame order
   logic [7:0]  b2;
   logic [7:0]  b3;
   logic [7:0]  b4;
   logic [7:0]  b5;
   logic [7:0]  b6;
   logic [7:0]  b7;
   logic [7:0]  b8;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         id <= '0;
         b1 <= '0;
         b2 <= '0;
         b3 <= '0;
         b4 <= '0;
         b5 <= '0;
         b6 <= '0;
         b7 <= '0;
         b8 <= '0;
      end
      else if (en)
      begin
         // upper half of a data register is the lower-numbered byte
         case (addr)
            RegId:
            begin
               id <= {1'b0, data[15:5]};      // id is left aligned
            end
            RegB12:
            begin
               b1 <= data[15:8];
               b2 <= data[7:0];
            end
            RegB34:
            begin
               b3 <= data[15:8];
               b4 <= data[7:0];
            end
            RegB56:
            begin
               b5 <= data[15:8];
               b6 <= data[7:0];
            end
            RegB78:
            begin
               b7 <= data[15:8];
               b8 <= data[7:0];
            end
            default:
            begin
            end                               // unmapped, hold contents
         endcase
      end
   end

   assign msgWord = {id, b1, b3, b2, b4, b8, b7, b6, b5};  // legacy ordering
   assign sdoCmd  = b1;
   assign curId   = id[10:0];

endmodule

`default_nettype wire

//--- hw/rxReadSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module rxReadSequencer
   import canBridgePkg::*;
(
   input  wire logic       clk,
   input  wire logic       rst,          // async, active low
   input  wire logic       frmPending,   // frame received pulse
   input  wire logic       rxEnable,     // bridge enabled
   output logic      [4:0] regAddr,      // receive register address
   output logic            regRd,        // read strobe
   output logic            msgDone       // all five reads captured
);

   SeqState state;
   SeqState stateNext;
   logic    pendFlag;                    // frame flagged while busy
   logic    newFrame;

   assign newFrame = frmPending && rxEnable;  // disabled bridge drops frames

   always_comb
   begin
      stateNext = state;
      case (state)
         SeqIdle:
         begin
            if (newFrame)
               stateNext = SeqId;
         end
         SeqId:   stateNext = SeqB12;
         SeqB12:  stateNext = SeqB34;
         SeqB34:  stateNext = SeqB56;
         SeqB56:  stateNext = SeqB78;
         SeqB78:  stateNext = SeqDone;
         SeqDone:
         begin
            // back to back frames skip idle
            if (pendFlag || newFrame)
               stateNext = SeqId;
            else
               stateNext = SeqIdle;
         end
         default: stateNext = SeqIdle;   // unused code
      endcase
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         state <= SeqIdle;
      else
         state <= stateNext;
   end

   // one deep pending store, consumed when leaving SeqDone
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         pendFlag <= 1'b0;
      else if (state == SeqDone)
         pendFlag <= 1'b0;
      else if (newFrame && state != SeqIdle)
         pendFlag <= 1'b1;
   end

   // address and strobe decoded straight from the state
   always_comb
   begin
      regAddr = '0;
      regRd   = 1'b1;
      case (state)
         SeqId:   regAddr = RegId;
         SeqB12:  regAddr = RegB12;
         SeqB34:  regAddr = RegB34;
         SeqB56:  regAddr = RegB56;
         SeqB78:  regAddr = RegB78;
         default: regRd   = 1'b0;        // idle and done do not read
      endcase
   end

   assign msgDone = (state == SeqDone);

endmodule

`default_nettype wire

//--- hw/sdoDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module sdoDecoder
   import canBridgePkg::*;
(
   input  wire logic                clk,
   input  wire logic                rst,       // async, active low
   input  wire logic                msgDone,   // buffer holds a full frame
   input  wire logic [MsgWidth-1:0] msgWord,
   input  wire logic [6:0]          nodeId,
   output logic                     sdoValid,  // one cycle result strobe
   output SdoOp                     sdoOp,
   output logic      [15:0]         sdoIndex,
   output logic      [7:0]          sdoSub,
   output logic      [31:0]         sdoData,
   output logic      [2:0]          sdoLen     // expedited byte count
);

   logic [11:0] idField;
   logic [7:0]  cmd;                         // b1, command specifier byte
   logic [15:0] index;
   logic [7:0]  sub;
   logic [31:0] payload;
   logic        idMatch;
   SdoOp        opNext;
   logic [2:0]  lenNext;

   // unpack the buffer word, see recMesBuf ordering
   assign idField = msgWord[75:64];
   assign cmd     = msgWord[63:56];
   assign index   = {msgWord[55:48], msgWord[47:40]};  // b3 high, b2 low
   assign sub     = msgWord[39:32];                    // b4
   assign payload = msgWord[31:0];                     // b8 down to b5

   assign idMatch = (idField == {1'b0, SdoRxBase + {4'b0, nodeId}});

   always_comb
   begin
      opNext  = SdoNone;
      lenNext = 3'd0;
      if (idMatch)
      begin
         case (cmd[7:5])
            3'd1:
            begin
               opNext = SdoDownload;
               // e and s set, n gives the unused bytes
               if (cmd[1] && cmd[0])
                  lenNext = 3'd4 - {1'b0, cmd[3:2]};
               else if (cmd[1])
                  lenNext = 3'd4;            // size not indicated
            end
            3'd2:    opNext = SdoUpload;
            default: opNext = SdoOther;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         sdoValid <= 1'b0;
         sdoOp    <= SdoNone;
      end
      else
      begin
         sdoValid <= msgDone;
         if (msgDone)
            sdoOp <= opNext;
      end
   end

   // result fields, zeroed for foreign frames
   always_ff @(posedge clk)
   begin
      if (msgDone)
      begin
         sdoIndex <= idMatch ? index   : '0;
         sdoSub   <= idMatch ? sub     : '0;
         sdoData  <= idMatch ? payload : '0;
         sdoLen   <= lenNext;
      end
   end

endmodule

`default_nettype wire

//--- hw/bridgeCfg.sv
`timescale 1ns/1ps
`default_nettype none

module bridgeCfg
   import canBridgePkg::*;
(
   input  wire logic       clk,
   input  wire logic       rst,        // async, active low
   input  wire logic       cfgWe,      // write at this edge
   input  wire logic [1:0] cfgAddr,
   input  wire logic [7:0] cfgWdata,
   input  wire logic       sdoValid,   // decoder result strobe
   input  wire SdoOp       sdoOp,
   output logic      [7:0] cfgRdata,   // combinational readback
   output logic            rxEnable,
   output logic      [6:0] nodeId
);

   logic [7:0] reqCount;               // accepted SDO requests
   logic       countHit;

   // only requests addressed to us are counted
   assign countHit = sdoValid && (sdoOp != SdoNone);

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         rxEnable <= 1'b0;
         nodeId   <= '0;
         reqCount <= '0;
      end
      else
      begin
         if (cfgWe && cfgAddr == CfgCtrl)
            rxEnable <= cfgWdata[0];
         if (cfgWe && cfgAddr == CfgNode)
            nodeId <= cfgWdata[6:0];
         if (cfgWe && cfgAddr == CfgCount)
            reqCount <= '0;            // any write clears, clear wins
         else if (countHit && reqCount != 8'hff)
            reqCount <= reqCount + 8'd1;  // saturate at 255
      end
   end

   always_comb
   begin
      case (cfgAddr)
         CfgCtrl:  cfgRdata = {7'b0, rxEnable};
         CfgNode:  cfgRdata = {1'b0, nodeId};
         CfgCount: cfgRdata = reqCount;
         default:  cfgRdata = '0;      // unmapped
      endcase
   end

endmodule

`default_nettype wire

//--- hw/canBridgeTop.sv
`timescale 1ns/1ps
`default_nettype none

module canBridgeTop
   import canBridgePkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst,         // async, active low
   input  wire logic        frmPending,  // from CAN controller
   input  wire logic [15:0] regData,     // receive register contents
   input  wire logic        cfgWe,
   input  wire logic [1:0]  cfgAddr,
   input  wire logic [7:0]  cfgWdata,
   output logic      [4:0]  regAddr,
   output logic             regRd,
   output logic      [7:0]  cfgRdata,
   output logic             sdoValid,
   output SdoOp             sdoOp,
   output logic      [15:0] sdoIndex,
   output logic      [7:0]  sdoSub,
   output logic      [31:0] sdoData,
   output logic      [2:0]  sdoLen,
   output logic      [10:0] curId        // id of last buffered frame
);

   logic                msgDone;         // sequencer to decoder
   logic [MsgWidth-1:0] msgWord;         // buffer to decoder
   logic                rxEnable;
   logic [6:0]          nodeId;

   rxReadSequencer iSequencer (
      .clk, .rst, .frmPending, .rxEnable, .regAddr, .regRd, .msgDone
   );

   // reads land in the buffer at the strobe edge
   recMesBuf iBuffer (
      .clk, .rst, .data(regData), .en(regRd), .addr(regAddr),
      .msgWord, .sdoCmd(), .curId
   );

   sdoDecoder iDecoder (
      .clk, .rst, .msgDone, .msgWord, .nodeId,
      .sdoValid, .sdoOp, .sdoIndex, .sdoSub, .sdoData, .sdoLen
   );

   bridgeCfg iConfig (
      .clk, .rst, .cfgWe, .cfgAddr, .cfgWdata,
      .sdoValid, .sdoOp, .cfgRdata, .rxEnable, .nodeId
   );

endmodule

`default_nettype wire

//--- sim/canBridgeTb.sv
`timescale 1ns/1ps
`default_nettype none

module canBridgeTb
   import canBridgePkg::*;
();

   logic        clk;
   logic        rst;
   logic        frmPending;
   logic [15:0] regData;
   logic        cfgWe;
   logic [1:0]  cfgAddr;
   logic [7:0]  cfgWdata;
   logic [4:0]  regAddr;
   logic        regRd;
   logic [7:0]  cfgRdata;
   logic        sdoValid;
   SdoOp        sdoOp;
   logic [15:0] sdoIndex;
   logic [7:0]  sdoSub;
   logic [31:0] sdoData;
   logic [2:0]  sdoLen;
   logic [10:0] curId;

   logic [15:0] regFile [0:31];                   // receive register model
   logic [31:0] lfsr;
   logic [6:0]  nodeSet;                          // node id written to the DUT
   logic [4:0]  addrSeen [$];                     // read addresses of last frame
   logic [4:0]  expOrder [0:4] = '{5'd5, 5'd3, 5'd2, 5'd1, 5'd0};
   int          errCount;
   int          testCount;
   int          failTests;

   canBridgeTop i_dut (
      .clk, .rst, .frmPending, .regData, .cfgWe, .cfgAddr, .cfgWdata,
      .regAddr, .regRd, .cfgRdata, .sdoValid, .sdoOp, .sdoIndex, .sdoSub,
      .sdoData, .sdoLen, .curId
   );

   assign regData = regFile[regAddr];             // answers in the same cycle

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;                      // 4 ns period
   end

   // fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic randBits(input int n, output logic [31:0] v);
      v = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr = lfsrNext(lfsr);                   // one step per bit
         v = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic checkOp(input string name, input SdoOp exp, input SdoOp act);
      if (exp !== act)
      begin
         $display("MISMATCH %s: expected %s, actual %s", name, exp.name(), act.name());
         errCount++;
      end
   endtask

   task automatic checkField(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
         errCount++;
      end
   endtask

   task automatic checkByte(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (exp !== act)
      begin
         $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
         errCount++;
      end
   endtask

   task automatic finishTest(input string name, input int errStart);
      testCount++;
      if (errCount == errStart)
         $display("[%s] ok", name);
      else
      begin
         failTests++;
         $display("[%s] %0d errors", name, errCount - errStart);
      end
   endtask

   task automatic cfgWrite(input logic [1:0] a, input logic [7:0] d);
      @(posedge clk);
      #1;
      cfgWe    = 1'b1;
      cfgAddr  = a;
      cfgWdata = d;
      @(posedge clk);                             // write lands here
      #1;
      cfgWe = 1'b0;
   endtask

   task automatic cfgRead(input logic [1:0] a, output logic [7:0] d);
      @(posedge clk);
      #1;
      cfgAddr = a;
      #1;
      d = cfgRdata;                               // combinational readback
   endtask

   // frame bytes b1..b8 from high to low in pl
   task automatic loadFrame(input logic [10:0] id, input logic [63:0] pl);
      regFile[5] = {id, 5'b0};                    // id left aligned
      regFile[3] = pl[63:48];
      regFile[2] = pl[47:32];
      regFile[1] = pl[31:16];
      regFile[0] = pl[15:0];
   endtask

   task automatic sendFrame();
      @(posedge clk);
      #1;
      frmPending = 1'b1;
      @(posedge clk);                             // sampled here, edge N
      #1;
      frmPending = 1'b0;
   endtask

   // lat counts cycles after edge N when called right after sendFrame
   task automatic waitResult(input string name, output int lat);
      logic got;
      got = 1'b0;
      lat = 0;
      addrSeen.delete();
      while (!got && lat < 40)
      begin
         @(negedge clk);
         lat++;
         if (regRd)
            addrSeen.push_back(regAddr);
         if (sdoValid)
            got = 1'b1;
      end
      if (!got)
      begin
         $display("ERROR %s: sdoValid did not arrive within 40 cycles", name);
         errCount++;
      end
   endtask

   task automatic expectQuiet(input string name, input int cycles);
      for (int k = 0; k < cycles; k++)
      begin
         @(negedge clk);
         if (regRd || sdoValid)
         begin
            $display("ERROR %s: register read or result seen while disabled", name);
            errCount++;
         end
      end
   endtask

   task automatic checkResult(input string name, input logic [10:0] id, input logic [63:0] pl);
      logic [7:0] cmd;
      logic       match;
      SdoOp       expOp;
      logic [2:0] expLen;
      cmd    = pl[63:56];
      match  = (id == SdoRxBase + {4'b0, nodeSet});
      expOp  = SdoNone;
      expLen = 3'd0;
      if (match)
      begin
         case (cmd[7:5])
            3'd1:    expOp = SdoDownload;
            3'd2:    expOp = SdoUpload;
            default: expOp = SdoOther;
         endcase
      end
      if (expOp == SdoDownload && cmd[1])
         expLen = cmd[0] ? 3'd4 - {1'b0, cmd[3:2]} : 3'd4;  // s bit picks n
      checkOp(name, expOp, sdoOp);
      checkField({name, " index"}, match ? {16'b0, pl[47:40], pl[55:48]} : 32'b0,
                 {16'b0, sdoIndex});
      checkField({name, " sub"}, match ? {24'b0, pl[39:32]} : 32'b0, {24'b0, sdoSub});
      checkField({name, " data"},
                 match ? {pl[7:0], pl[15:8], pl[23:16], pl[31:24]} : 32'b0, sdoData);
      checkByte({name, " length"}, {5'b0, expLen}, {5'b0, sdoLen});
   endtask

   task automatic cfgReadback();
      int         errStart;
      logic [7:0] rd;
      errStart = errCount;
      cfgRead(CfgCount, rd);
      checkByte("count after reset", 8'd0, rd);
      cfgWrite(CfgNode, 8'h25);
      nodeSet = 7'h25;
      cfgRead(CfgNode, rd);
      checkByte("node id", 8'h25, rd);
      cfgWrite(CfgCtrl, 8'h01);
      cfgRead(CfgCtrl, rd);
      checkByte("enable", 8'h01, rd);
      cfgWrite(CfgCount, 8'h5a);                  // any value clears
      cfgRead(CfgCount, rd);
      checkByte("count after clear", 8'd0, rd);
      finishTest("cfgReadback", errStart);
   endtask

   task automatic expeditedDownload();
      int          errStart;
      int          lat;
      logic [31:0] idx;
      logic [31:0] sub;
      logic [31:0] dat;
      logic [31:0] n;
      logic [10:0] id;
      logic [63:0] pl;
      logic [7:0]  cnt0;
      logic [7:0]  cnt1;
      errStart = errCount;
      for (int t = 0; t < 3; t++)
      begin
         randBits(16, idx);
         randBits(8, sub);
         randBits(32, dat);
         randBits(2, n);
         id = SdoRxBase + {4'b0, nodeSet};
         pl = {3'b001, 1'b0, n[1:0], 2'b11, idx[7:0], idx[15:8], sub[7:0],
               dat[7:0], dat[15:8], dat[23:16], dat[31:24]};  // e and s set
         cfgRead(CfgCount, cnt0);
         loadFrame(id, pl);
         sendFrame();
         waitResult("download", lat);
         checkResult("download", id, pl);
         checkByte("download latency", 8'd7, 8'(lat));
         checkByte("download reads", 8'd5, 8'(addrSeen.size()));
         for (int k = 0; k < addrSeen.size() && k < 5; k++)
            checkByte("download address", {3'b0, expOrder[k]}, {3'b0, addrSeen[k]});
         cfgRead(CfgCount, cnt1);
         checkByte("download count", cnt0 + 8'd1, cnt1);
      end
      finishTest("expeditedDownload", errStart);
   endtask

   task automatic uploadAndOther();
      int          errStart;
      int          lat;
      logic [31:0] idx;
      logic [31:0] sub;
      logic [10:0] id;
      logic [63:0] pl;
      logic [7:0]  cnt0;
      logic [7:0]  cnt1;
      errStart = errCount;
      randBits(16, idx);
      randBits(8, sub);
      id = SdoRxBase + {4'b0, nodeSet};
      pl = {8'h40, idx[7:0], idx[15:8], sub[7:0], 32'h0};  // ccs 2
      cfgRead(CfgCount, cnt0);
      loadFrame(id, pl);
      sendFrame();
      waitResult("upload", lat);
      checkResult("upload", id, pl);
      cfgRead(CfgCount, cnt1);
      checkByte("upload count", cnt0 + 8'd1, cnt1);
      pl[63:56] = 8'h80;                          // ccs 4, abort
      loadFrame(id, pl);
      sendFrame();
      waitResult("other", lat);
      checkResult("other", id, pl);
      cfgRead(CfgCount, cnt0);
      checkByte("other count", cnt1 + 8'd1, cnt0);
      finishTest("uploadAndOther", errStart);
   endtask

   task automatic foreignAndDisable();
      int          errStart;
      int          lat;
      logic [31:0] dat;
      logic [10:0] id;
      logic [63:0] pl;
      logic [7:0]  cnt0;
      logic [7:0]  cnt1;
      errStart = errCount;
      randBits(32, dat);
      id = SdoRxBase + {4'b0, nodeSet} + 11'd1;   // next node's request
      pl = {8'h23, 8'h00, 8'h20, 8'h01, dat};
      cfgRead(CfgCount, cnt0);
      loadFrame(id, pl);
      sendFrame();
      waitResult("foreign", lat);
      checkResult("foreign", id, pl);
      cfgRead(CfgCount, cnt1);
      checkByte("foreign count", cnt0, cnt1);
      cfgWrite(CfgCount, 8'h00);
      cfgRead(CfgCount, cnt1);
      checkByte("count after clear", 8'd0, cnt1);
      cfgWrite(CfgCtrl, 8'h00);
      sendFrame();
      expectQuiet("disabled", 20);
      cfgWrite(CfgCtrl, 8'h01);
      expectQuiet("re-enabled", 10);              // no pending frame kept
      finishTest("foreignAndDisable", errStart);
   endtask

   task automatic pendingWhileBusy();
      int          errStart;
      int          lat;
      logic [31:0] dat;
      logic [31:0] dat2;
      logic [10:0] id1;
      logic [10:0] id2;
      logic [63:0] pl1;
      logic [63:0] pl2;
      errStart = errCount;
      randBits(32, dat);
      randBits(32, dat2);
      id1 = SdoRxBase + {4'b0, nodeSet} + 11'd3;  // foreign first frame
      id2 = SdoRxBase + {4'b0, nodeSet};
      pl1 = {8'h2b, dat[23:0], dat2};
      pl2 = {8'h40, dat2, dat[23:0]};
      loadFrame(id1, pl1);
      sendFrame();
      @(posedge clk);
      #1;
      frmPending = 1'b1;                          // arrives during the reads
      @(posedge clk);
      #1;
      frmPending = 1'b0;
      repeat (3) @(posedge clk);                  // last read of frame 1 done
      #1;
      loadFrame(id2, pl2);
      waitResult("pending first", lat);
      checkResult("pending first", id1, pl1);
      waitResult("pending second", lat);
      checkResult("pending second", id2, pl2);
      checkField("pending curId", {21'b0, id2}, {21'b0, curId});
      finishTest("pendingWhileBusy", errStart);
   endtask

   initial
   begin
      rst        = 1'b0;
      frmPending = 1'b0;
      cfgWe      = 1'b0;
      cfgAddr    = 2'd0;
      cfgWdata   = 8'd0;
      lfsr       = 32'hd1ed;
      nodeSet    = 7'd0;
      errCount   = 0;
      testCount  = 0;
      failTests  = 0;
      for (int i = 0; i < 32; i++)
         regFile[i] = {11'h4b3, 5'(i)};           // per address fill
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b1;
      cfgReadback();
      expeditedDownload();
      uploadAndOther();
      foreignAndDisable();
      pendingWhileBusy();
      $display("tests %0d, failing tests %0d, errors %0d", testCount, failTests, errCount);
      if (errCount == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- canBridge.f
hw/canBridgePkg.sv
hw/recMesBuf.sv
hw/rxReadSequencer.sv
hw/sdoDecoder.sv
hw/bridgeCfg.sv
hw/canBridgeTop.sv
sim/canBridgeTb.sv

//--- run.sh
#!/bin/bash
# builds the CAN bridge testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -j 0 --top-module canBridgeTb \
      -f canBridge.f -o canBridgeSim --Mdir obj_dir \
   && ./obj_dir/canBridgeSim | tee sim.log \
   && grep -q "^Test passed$" sim.log \
   && echo "run.sh: simulation ok" \
   || { echo "run.sh: simulation failed"; exit 1; }
